//--- tb/aib_avalon_golden.txt
# Command then hex fields: write addr data be | read addr data|miss | status g1 g2 d1 d2
# ack tx|rx | check port value. Channel 05 sits at 2800, adapter 2A00, IO 2B00
check waitreq 0
check rdatavld 0
check tx_ld 0
check rx_ld 0
check tx_div 1
check rx_div 1
read 2A00 00000000
read 2B0C 00000000
write 2A00 11223344 f
write 2A04 a5a5a5a5 5
write 2A08 deadbeef c
write 2A0C 01020304 3
write 2B00 cafef00d f
write 2B04 12345678 9
write 2B08 87654321 6
write 2B0C 0badc0de f
check rx_adapt_1 00a500a5
check tx_adapt_0 dead0000
check redund_1 12000078
check redund_2 00654300
read 2A0C 00000304
read 2B04 12000078
write 2A10 000000ac 1
check tx_div 4
check rx_div 2
read 2A10 000000ac
ack tx
check tx_ld 0
read 2A10 000000a4
ack rx
read 2A10 00000024
status 5a 33 1 1
read 2B10 0003335a
write 2B10 ffffffff f
read 2B10 0003335a
write 3200 ffffffff f
write 2900 ffffffff f
write 2C00 ffffffff f
check rx_adapt_0 11223344
check redund_0 cafef00d
read 3200 miss
read 2900 miss
read 2C00 miss
read 2A40 00000000

//--- flist.f
verilog/aib_cfg_pkg.sv
verilog/aib_avalon_bridge.sv
verilog/aib_avalon_adapt_reg.sv
verilog/aib_avalon_io_regs.sv
verilog/aib_avalon.sv
tb/aib_avalon_properties.sv
tb/tb_aib_avalon.sv

//--- tb/tb_aib_avalon.sv
// ----------------------------------------
// Testbench for the AIB channel config slave
// Golden script drives the host, a local model cross-checks it
// Channel ID fixed at 05, four redundancy registers built
// ----------------------------------------
`timescale 1ns/1ps

module tb_aib_avalon;

  import aib_cfg_pkg::*;

  localparam int    TIMEOUT   = 16;  // Cycles per handshake wait
  localparam int    MISS_WAIT = 8;   // Quiet cycles after an ignored read
  localparam string GOLDEN    = "tb/aib_avalon_golden.txt";

  logic         cfg_avmm_clk;
  logic         rst_n;
  chan_id_t     cfg_avmm_addr_id;
  logic         cfg_avmm_write, cfg_avmm_read;
  avmm_addr_t   cfg_avmm_addr;
  csr_data_t    cfg_avmm_wdata;
  byte_en_t     cfg_avmm_byte_en;
  csr_data_t    cfg_avmm_rdata;
  logic         cfg_avmm_rdatavld, cfg_avmm_waitreq;
  csr_data_t    rx_adapt_0, rx_adapt_1, tx_adapt_0, tx_adapt_1;
  logic         tx_clk_div_ld_ff, tx_clk_div_1_ff, tx_clk_div_2_ff, tx_clk_div_4_ff;
  logic         rx_clk_div_ld_ff, rx_clk_div_1_ff, rx_clk_div_2_ff, rx_clk_div_4_ff;
  logic         tx_clk_div_ld_ack, rx_clk_div_ld_ack;
  csr_data_t    redund_0, redund_1, redund_2, redund_3;
  logic [6:0]   rcomp_calcode_g1, rcomp_calcode_g2;
  logic         rcomp_cal_done_g1_sync, rcomp_cal_done_g2_sync;

  csr_data_t    adapt_m [4];  // rx0, rx1, tx0, tx1
  csr_data_t    redund_m [4];
  clk_div_sel_t tx_sel_m, rx_sel_m;
  logic         tx_ld_m, rx_ld_m;

  aib_avalon #(.NUM_REDUND(4)) i_aib_avalon (.*);

  initial begin
    cfg_avmm_clk = 1'b0;
    forever #2 cfg_avmm_clk = ~cfg_avmm_clk;  // 4 ns period
  end

  // ----------------------------------------
  // Reporting
  // ----------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_value(input string what, input csr_data_t got, input csr_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t ns %s: got %08h, expected %08h", $time, what, got, exp));
    end
  endtask

  function automatic int prop_fails();
    return i_aib_avalon.i_bridge.i_bridge_props.fail_count +
           i_aib_avalon.i_adapt_reg.i_adapt_props.fail_count;
  endfunction

  always @(negedge cfg_avmm_clk) begin
    if (prop_fails() != 0) abort_run("A bound assertion on the DUT failed");
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic csr_data_t merge_bytes(input csr_data_t old_v, input csr_data_t new_v,
                                            input byte_en_t be);
    csr_data_t lane_mask;
    lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_v & ~lane_mask) | (new_v & lane_mask);
  endfunction

  // Own channel, offsets 0x200 to 0x3FF
  function automatic logic model_hit(input avmm_addr_t a);
    return (a[16:11] == 6'h05) && (a[10:0] >= 11'h200) && (a[10:0] < 11'h400);
  endfunction

  function automatic csr_data_t model_read(input avmm_addr_t a);
    csr_data_t w;
    w = '0;
    if (a[7:0] < 8'h10 && a[1:0] == 2'b00) begin
      w = a[8] ? redund_m[a[3:2]] : adapt_m[a[3:2]];  // a[8] set is IO block
    end else if (a[7:0] == 8'h10 && !a[8]) begin
      w = {24'd0, rx_ld_m, rx_sel_m, tx_ld_m, tx_sel_m};
    end else if (a[7:0] == 8'h10) begin
      w[6:0]  = rcomp_calcode_g1;   // RCOMP status layout
      w[14:8] = rcomp_calcode_g2;
      w[16]   = rcomp_cal_done_g1_sync;
      w[17]   = rcomp_cal_done_g2_sync;
    end
    return w;
  endfunction

  task automatic model_write(input avmm_addr_t a, input csr_data_t wd, input byte_en_t be);
    if (model_hit(a) && a[7:0] < 8'h10 && a[1:0] == 2'b00) begin
      if (a[8]) redund_m[a[3:2]] = merge_bytes(redund_m[a[3:2]], wd, be);
      else adapt_m[a[3:2]] = merge_bytes(adapt_m[a[3:2]], wd, be);
    end else if (model_hit(a) && a[7:0] == 8'h10 && !a[8] && be[0]) begin
      tx_sel_m = wd[2:0];
      rx_sel_m = wd[6:4];
      if (wd[3]) tx_ld_m = 1'b1;  // Load requests
      if (wd[7]) rx_ld_m = 1'b1;
    end
  endtask

  // {known, dut value, model value}
  function automatic logic [64:0] port_pair(input string name);
    case (name)
      "rx_adapt_0": return {1'b1, rx_adapt_0, adapt_m[0]};
      "rx_adapt_1": return {1'b1, rx_adapt_1, adapt_m[1]};
      "tx_adapt_0": return {1'b1, tx_adapt_0, adapt_m[2]};
      "tx_adapt_1": return {1'b1, tx_adapt_1, adapt_m[3]};
      "redund_0":   return {1'b1, redund_0, redund_m[0]};
      "redund_1":   return {1'b1, redund_1, redund_m[1]};
      "redund_2":   return {1'b1, redund_2, redund_m[2]};
      "redund_3":   return {1'b1, redund_3, redund_m[3]};
      "tx_ld":      return {1'b1, 31'd0, tx_clk_div_ld_ff, 31'd0, tx_ld_m};
      "rx_ld":      return {1'b1, 31'd0, rx_clk_div_ld_ff, 31'd0, rx_ld_m};
      "tx_div":     return {1'b1, 29'd0, tx_clk_div_4_ff, tx_clk_div_2_ff, tx_clk_div_1_ff,
                            29'd0, tx_sel_m};
      "rx_div":     return {1'b1, 29'd0, rx_clk_div_4_ff, rx_clk_div_2_ff, rx_clk_div_1_ff,
                            29'd0, rx_sel_m};
      "waitreq":    return {1'b1, 31'd0, cfg_avmm_waitreq, 32'd0};
      "rdatavld":   return {1'b1, 31'd0, cfg_avmm_rdatavld, 32'd0};
      default:      return '0;
    endcase
  endfunction

  // Every register output against the model
  task automatic sweep_ports();
    string       names [12];
    logic [64:0] pair;
    names = '{"rx_adapt_0", "rx_adapt_1", "tx_adapt_0", "tx_adapt_1",
              "redund_0", "redund_1", "redund_2", "redund_3",
              "tx_ld", "rx_ld", "tx_div", "rx_div"};
    foreach (names[i]) begin
      pair = port_pair(names[i]);
      check_value({names[i], " final"}, pair[63:32], pair[31:0]);
    end
  endtask

  // ----------------------------------------
  // Host side
  // ----------------------------------------
  task automatic next_cycle();
    @(posedge cfg_avmm_clk);
    #0.5;  // Drive just after the edge
  endtask

  // Request taken at the edge after waitreq is seen low
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge cfg_avmm_clk);
    while (cfg_avmm_waitreq && n < TIMEOUT) begin
      @(negedge cfg_avmm_clk);
      n++;
    end
    if (cfg_avmm_waitreq) abort_run("Timeout: waitreq stayed high for 16 cycles");
    next_cycle();
  endtask

  task automatic host_write(input avmm_addr_t a, input csr_data_t wd, input byte_en_t be);
    cfg_avmm_addr    = a;
    cfg_avmm_wdata   = wd;
    cfg_avmm_byte_en = be;
    cfg_avmm_write   = 1'b1;
    wait_accept();
    cfg_avmm_write   = 1'b0;
    model_write(a, wd, be);
  endtask

  task automatic host_read(input avmm_addr_t a, input string exp_s);
    csr_data_t exp_v;
    int        n;
    int        rc;
    check_value($sformatf("decode of %05h", a), csr_data_t'(model_hit(a)),
                csr_data_t'(exp_s != "miss"));  // Golden and model agree on decode
    cfg_avmm_addr = a;
    cfg_avmm_read = 1'b1;
    @(negedge cfg_avmm_clk);  // Hit read stalls in its idle cycle
    check_value($sformatf("waitreq as read %05h is sampled", a),
                csr_data_t'(cfg_avmm_waitreq), csr_data_t'(model_hit(a)));
    wait_accept();
    cfg_avmm_read = 1'b0;
    if (exp_s == "miss") begin
      for (n = 0; n < MISS_WAIT; n++) begin
        @(negedge cfg_avmm_clk);
        check_value($sformatf("rdatavld after ignored read %05h", a),
                    csr_data_t'(cfg_avmm_rdatavld), '0);
      end
    end else begin
      rc = $sscanf(exp_s, "%h", exp_v);
      if (rc != 1) abort_run("Golden file has an unreadable expected value");
      check_value($sformatf("model read %05h", a), model_read(a), exp_v);
      n = 0;
      @(negedge cfg_avmm_clk);
      while (!cfg_avmm_rdatavld && n < TIMEOUT) begin
        @(negedge cfg_avmm_clk);
        n++;
      end
      if (!cfg_avmm_rdatavld) abort_run("Timeout: rdatavld never rose after a read");
      check_value($sformatf("read %05h", a), cfg_avmm_rdata, exp_v);
    end
    next_cycle();
  endtask

  task automatic pulse_ack(input string which);
    if (which == "tx") tx_clk_div_ld_ack = 1'b1;
    else if (which == "rx") rx_clk_div_ld_ack = 1'b1;
    else abort_run("Golden file names an unknown ack");
    next_cycle();
    tx_clk_div_ld_ack = 1'b0;
    rx_clk_div_ld_ack = 1'b0;
    if (which == "tx") tx_ld_m = 1'b0;  // Flag clears on ack
    else rx_ld_m = 1'b0;
  endtask

  // ----------------------------------------
  // Golden script runner
  // ----------------------------------------
  initial begin
    string             cmd;
    string             arg_s;
    logic [8*160-1:0]  line_buf;
    int                fd;
    int                rc;
    avmm_addr_t        a;
    csr_data_t         wd;
    byte_en_t          be;
    logic [64:0]       pair;
    rst_n = 1'b0;
    cfg_avmm_addr_id = 6'h05;
    cfg_avmm_write = 1'b0;
    cfg_avmm_read = 1'b0;
    cfg_avmm_addr = '0;
    cfg_avmm_wdata = '0;
    cfg_avmm_byte_en = '0;
    tx_clk_div_ld_ack = 1'b0;
    rx_clk_div_ld_ack = 1'b0;
    rcomp_calcode_g1 = '0;
    rcomp_calcode_g2 = '0;
    rcomp_cal_done_g1_sync = 1'b0;
    rcomp_cal_done_g2_sync = 1'b0;
    adapt_m = '{default: '0};
    redund_m = '{default: '0};
    tx_sel_m = 3'b001;  // Divide by 1
    rx_sel_m = 3'b001;
    tx_ld_m = 1'b0;
    rx_ld_m = 1'b0;
    repeat (4) @(posedge cfg_avmm_clk);
    #0.5;
    rst_n = 1'b1;

    fd = $fopen(GOLDEN, "r");
    if (fd == 0) abort_run("Cannot open the golden script");
    while (!$feof(fd)) begin
      rc = $fscanf(fd, "%s", cmd);
      if (rc != 1) begin
        // Trailing blank space at end of file
      end else if (cmd[0] == "#") begin
        rc = $fgets(line_buf, fd);  // Skip comment text
      end else if (cmd == "write") begin
        rc = $fscanf(fd, "%h %h %h", a, wd, be);
        host_write(a, wd, be);
      end else if (cmd == "read") begin
        rc = $fscanf(fd, "%h %s", a, arg_s);
        host_read(a, arg_s);
      end else if (cmd == "status") begin
        rc = $fscanf(fd, "%h %h %h %h", rcomp_calcode_g1, rcomp_calcode_g2,
                     rcomp_cal_done_g1_sync, rcomp_cal_done_g2_sync);
        next_cycle();
      end else if (cmd == "ack") begin
        rc = $fscanf(fd, "%s", arg_s);
        pulse_ack(arg_s);
      end else if (cmd == "check") begin
        rc = $fscanf(fd, "%s %h", arg_s, wd);
        pair = port_pair(arg_s);
        if (!pair[64]) abort_run("Golden file checks an unknown port");
        check_value({arg_s, " model"}, pair[31:0], wd);
        check_value(arg_s, pair[63:32], wd);
      end else begin
        abort_run("Golden file holds an unknown command");
      end
    end
    $fclose(fd);
    sweep_ports();

    if (prop_fails() != 0) begin
      abort_run("A bound assertion on the DUT failed");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- tb/aib_avalon_properties.sv
// ----------------------------------------
// Bridge handshake and divider load checks
// Bound twice, unused inputs tie to zero
// ----------------------------------------
`timescale 1ns/1ps

module aib_avalon_properties (
  input logic clk,
  input logic rst_n,
  input logic rd_req,    // Read taken in idle
  input logic rdatavld,
  input logic tx_ld,     // TX load flag
  input logic tx_ack,
  input logic rx_ld,     // RX load flag
  input logic rx_ack
);

  int unsigned fail_count = 0;  // Polled by the testbench

  // Single cycle data valid
  assert property (@(posedge clk) disable iff (!rst_n) rdatavld |=> !rdatavld)
    else begin
      $error("rdatavld high for more than one cycle");
      fail_count++;
    end

  // Data valid two edges after the read is taken
  assert property (@(posedge clk) disable iff (!rst_n) rdatavld |-> $past(rd_req, 2))
    else begin
      $error("rdatavld without a read two edges earlier");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) $fell(tx_ld) |-> $past(tx_ack))
    else begin
      $error("TX load flag fell without ack");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) $fell(rx_ld) |-> $past(rx_ack))
    else begin
      $error("RX load flag fell without ack");
      fail_count++;
    end

endmodule

bind aib_avalon_bridge aib_avalon_properties i_bridge_props (
  .clk(cfg_avmm_clk), .rst_n(rst_n), .rd_req(rd_req), .rdatavld(cfg_avmm_rdatavld),
  .tx_ld(1'b0), .tx_ack(1'b0), .rx_ld(1'b0), .rx_ack(1'b0)
);

bind aib_avalon_adapt_reg aib_avalon_properties i_adapt_props (
  .clk(cfg_avmm_clk), .rst_n(rst_n), .rd_req(1'b0), .rdatavld(1'b0),
  .tx_ld(tx_clk_div_ld_ff), .tx_ack(tx_clk_div_ld_ack),
  .rx_ld(rx_clk_div_ld_ff), .rx_ack(rx_clk_div_ld_ack)
);

//--- verilog/aib_avalon.sv
// ----------------------------------------
// AIB channel configuration slave, top level
// Single clock domain, sync active low reset
// ----------------------------------------
`timescale 1ns/1ps

module aib_avalon #(
  parameter int NUM_REDUND = 4  // Redundancy registers, 1 to 4
) (
  input  logic                   cfg_avmm_clk,
  input  logic                   rst_n,
  input  aib_cfg_pkg::chan_id_t   cfg_avmm_addr_id,
  input  logic                   cfg_avmm_write,
  input  logic                   cfg_avmm_read,
  input  aib_cfg_pkg::avmm_addr_t cfg_avmm_addr,
  input  aib_cfg_pkg::csr_data_t  cfg_avmm_wdata,
  input  aib_cfg_pkg::byte_en_t   cfg_avmm_byte_en,
  output aib_cfg_pkg::csr_data_t  cfg_avmm_rdata,
  output logic                   cfg_avmm_rdatavld,
  output logic                   cfg_avmm_waitreq,
  output aib_cfg_pkg::csr_data_t  rx_adapt_0,
  output aib_cfg_pkg::csr_data_t  rx_adapt_1,
  output aib_cfg_pkg::csr_data_t  tx_adapt_0,
  output aib_cfg_pkg::csr_data_t  tx_adapt_1,
  output logic                   tx_clk_div_ld_ff,
  output logic                   tx_clk_div_1_ff,
  output logic                   tx_clk_div_2_ff,
  output logic                   tx_clk_div_4_ff,
  input  logic                   tx_clk_div_ld_ack,
  output logic                   rx_clk_div_ld_ff,
  output logic                   rx_clk_div_1_ff,
  output logic                   rx_clk_div_2_ff,
  output logic                   rx_clk_div_4_ff,
  input  logic                   rx_clk_div_ld_ack,
  output aib_cfg_pkg::csr_data_t  redund_0,
  output aib_cfg_pkg::csr_data_t  redund_1,
  output aib_cfg_pkg::csr_data_t  redund_2,
  output aib_cfg_pkg::csr_data_t  redund_3,
  input  logic [6:0]             rcomp_calcode_g1,
  input  logic [6:0]             rcomp_calcode_g2,
  input  logic                   rcomp_cal_done_g1_sync,
  input  logic                   rcomp_cal_done_g2_sync
);

  import aib_cfg_pkg::*;

  logic      adapt_write;  // Bridge to adapter block
  logic      adapt_read;
  logic      io_write;     // Bridge to IO block
  logic      io_read;
  csr_addr_t csr_addr;
  csr_data_t csr_wdata;
  byte_en_t  csr_byteen;
  csr_data_t adapt_rdata;
  csr_data_t io_rdata;

  aib_avalon_bridge i_bridge (
    .cfg_avmm_clk, .rst_n, .cfg_avmm_addr_id, .cfg_avmm_write, .cfg_avmm_read,
    .cfg_avmm_addr, .cfg_avmm_wdata, .cfg_avmm_byte_en, .cfg_avmm_rdata,
    .cfg_avmm_rdatavld, .cfg_avmm_waitreq, .adapt_write, .adapt_read,
    .io_write, .io_read, .csr_addr, .csr_wdata, .csr_byteen,
    .adapt_rdata, .io_rdata
  );

  aib_avalon_adapt_reg i_adapt_reg (
    .cfg_avmm_clk, .rst_n,
    .write      (adapt_write),
    .read       (adapt_read),
    .address    (csr_addr),
    .writedata  (csr_wdata),
    .byteenable (csr_byteen),
    .readdata   (adapt_rdata),
    .rx_adapt_0, .rx_adapt_1, .tx_adapt_0, .tx_adapt_1,
    .tx_clk_div_ld_ff, .tx_clk_div_1_ff, .tx_clk_div_2_ff, .tx_clk_div_4_ff,
    .tx_clk_div_ld_ack,
    .rx_clk_div_ld_ff, .rx_clk_div_1_ff, .rx_clk_div_2_ff, .rx_clk_div_4_ff,
    .rx_clk_div_ld_ack
  );

  aib_avalon_io_regs #(.NUM_REDUND(NUM_REDUND)) i_io_regs (
    .cfg_avmm_clk, .rst_n,
    .write      (io_write),
    .read       (io_read),
    .address    (csr_addr),
    .writedata  (csr_wdata),
    .byteenable (csr_byteen),
    .readdata   (io_rdata),
    .redund_0, .redund_1, .redund_2, .redund_3,
    .rcomp_calcode_g1, .rcomp_calcode_g2,
    .rcomp_cal_done_g1_sync, .rcomp_cal_done_g2_sync
  );

endmodule

//--- verilog/aib_avalon_io_regs.sv
// ----------------------------------------
// IO redundancy CSRs and RCOMP status
// NUM_REDUND from 1 to 4, unused outputs tie to zero
// RCOMP inputs are assumed already synchronized
// ----------------------------------------
`timescale 1ns/1ps

module aib_avalon_io_regs #(
  parameter int NUM_REDUND = 4  // Implemented redundancy registers
) (
  input  logic                  cfg_avmm_clk,
  input  logic                  rst_n,
  input  logic                  write,
  input  logic                  read,
  input  aib_cfg_pkg::csr_addr_t address,
  input  aib_cfg_pkg::csr_data_t writedata,
  input  aib_cfg_pkg::byte_en_t  byteenable,
  output aib_cfg_pkg::csr_data_t readdata,
  output aib_cfg_pkg::csr_data_t redund_0,
  output aib_cfg_pkg::csr_data_t redund_1,
  output aib_cfg_pkg::csr_data_t redund_2,
  output aib_cfg_pkg::csr_data_t redund_3,
  input  logic [6:0]            rcomp_calcode_g1,
  input  logic [6:0]            rcomp_calcode_g2,
  input  logic                  rcomp_cal_done_g1_sync,
  input  logic                  rcomp_cal_done_g2_sync
);

  import aib_cfg_pkg::*;

  csr_data_t redund_w [4];  // Register or zero per slot
  csr_data_t rcomp_word;

  // ----------------------------------------
  // Redundancy registers
  // ----------------------------------------
  for (genvar k = 0; k < 4; k++) begin : g_redund
    if (k < NUM_REDUND) begin : g_reg
      csr_data_t redund_q;
      always_ff @(posedge cfg_avmm_clk) begin
        if (!rst_n) begin
          redund_q <= '0;
        end else if (write && (address == csr_addr_t'(IO_REDUND_OFS + 4 * k))) begin
          redund_q <= byte_mask_wr(redund_q, writedata, byteenable);
        end
      end
      assign redund_w[k] = redund_q;
    end else begin : g_none
      assign redund_w[k] = '0;   // Slot not built
    end
  end

  assign redund_0 = redund_w[0];
  assign redund_1 = redund_w[1];
  assign redund_2 = redund_w[2];
  assign redund_3 = redund_w[3];

  // Read only, writes to this offset fall through
  assign rcomp_word = {14'd0, rcomp_cal_done_g2_sync, rcomp_cal_done_g1_sync,
                       1'b0, rcomp_calcode_g2, 1'b0, rcomp_calcode_g1};

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    readdata = '0;
    if (read) begin
      if (address == IO_RCOMP_OFS) readdata = rcomp_word;
      for (int n = 0; n < 4; n++) begin
        if (address == csr_addr_t'(IO_REDUND_OFS + 4 * n)) readdata = redund_w[n];
      end
    end
  end

endmodule

//--- verilog/aib_avalon_adapt_reg.sv
// ----------------------------------------
// Adapter control and clock divider CSRs
// Strobes are trusted, range check is upstream
// Divider selects are stored as written, not checked
// ----------------------------------------
`timescale 1ns/1ps

module aib_avalon_adapt_reg (
  input  logic                  cfg_avmm_clk,
  input  logic                  rst_n,
  input  logic                  write,
  input  logic                  read,
  input  aib_cfg_pkg::csr_addr_t address,
  input  aib_cfg_pkg::csr_data_t writedata,
  input  aib_cfg_pkg::byte_en_t  byteenable,
  output aib_cfg_pkg::csr_data_t readdata,
  output aib_cfg_pkg::csr_data_t rx_adapt_0,        // RX0 adapter register
  output aib_cfg_pkg::csr_data_t rx_adapt_1,        // RX1 adapter register
  output aib_cfg_pkg::csr_data_t tx_adapt_0,        // TX0 adapter register
  output aib_cfg_pkg::csr_data_t tx_adapt_1,        // TX1 adapter register
  output logic                  tx_clk_div_ld_ff,  // TX divider load request
  output logic                  tx_clk_div_1_ff,
  output logic                  tx_clk_div_2_ff,
  output logic                  tx_clk_div_4_ff,
  input  logic                  tx_clk_div_ld_ack,
  output logic                  rx_clk_div_ld_ff,  // RX divider load request
  output logic                  rx_clk_div_1_ff,
  output logic                  rx_clk_div_2_ff,
  output logic                  rx_clk_div_4_ff,
  input  logic                  rx_clk_div_ld_ack
);

  import aib_cfg_pkg::*;

  clk_div_sel_t tx_sel_q;
  clk_div_sel_t rx_sel_q;
  logic         div_wr;  // Byte 0 write to divider register

  assign div_wr = write & (address == ADAPT_CLKDIV_OFS) & byteenable[0];

  // ----------------------------------------
  // Adapter control registers
  // ----------------------------------------
  always_ff @(posedge cfg_avmm_clk) begin
    if (!rst_n) begin
      rx_adapt_0 <= '0;
      rx_adapt_1 <= '0;
      tx_adapt_0 <= '0;
      tx_adapt_1 <= '0;
    end else if (write) begin
      case (address)
        ADAPT_RX0_OFS: rx_adapt_0 <= byte_mask_wr(rx_adapt_0, writedata, byteenable);
        ADAPT_RX1_OFS: rx_adapt_1 <= byte_mask_wr(rx_adapt_1, writedata, byteenable);
        ADAPT_TX0_OFS: tx_adapt_0 <= byte_mask_wr(tx_adapt_0, writedata, byteenable);
        ADAPT_TX1_OFS: tx_adapt_1 <= byte_mask_wr(tx_adapt_1, writedata, byteenable);
        default: ;
      endcase
    end
  end

  // ----------------------------------------
  // Clock divider selects and load flags
  // ----------------------------------------
  always_ff @(posedge cfg_avmm_clk) begin
    if (!rst_n) begin
      tx_sel_q <= CLKDIV_RESET;
      rx_sel_q <= CLKDIV_RESET;
    end else if (div_wr) begin
      tx_sel_q <= writedata[2:0]; // TX select, bits 2..0
      rx_sel_q <= writedata[6:4]; // RX select, bits 6..4
    end
  end

  // New load request wins over a same-cycle ack
  always_ff @(posedge cfg_avmm_clk) begin
    if (!rst_n) begin
      tx_clk_div_ld_ff <= 1'b0;
      rx_clk_div_ld_ff <= 1'b0;
    end else begin
      if (div_wr && writedata[3])  tx_clk_div_ld_ff <= 1'b1;
      else if (tx_clk_div_ld_ack)  tx_clk_div_ld_ff <= 1'b0;
      if (div_wr && writedata[7])  rx_clk_div_ld_ff <= 1'b1;
      else if (rx_clk_div_ld_ack)  rx_clk_div_ld_ff <= 1'b0;
    end
  end

  assign tx_clk_div_1_ff = tx_sel_q[0];
  assign tx_clk_div_2_ff = tx_sel_q[1];
  assign tx_clk_div_4_ff = tx_sel_q[2];
  assign rx_clk_div_1_ff = rx_sel_q[0];
  assign rx_clk_div_2_ff = rx_sel_q[1];
  assign rx_clk_div_4_ff = rx_sel_q[2];

  // Zero unless read, unmapped offsets read zero
  always_comb begin
    readdata = '0;
    if (read) begin
      case (address)
        ADAPT_RX0_OFS:    readdata = rx_adapt_0;
        ADAPT_RX1_OFS:    readdata = rx_adapt_1;
        ADAPT_TX0_OFS:    readdata = tx_adapt_0;
        ADAPT_TX1_OFS:    readdata = tx_adapt_1;
        ADAPT_CLKDIV_OFS: readdata = {24'd0, rx_clk_div_ld_ff, rx_sel_q,
                                      tx_clk_div_ld_ff, tx_sel_q};
        default:          readdata = '0;
      endcase
    end
  end

endmodule

//--- verilog/aib_avalon_bridge.sv
// ----------------------------------------
// Avalon-MM slave front end of one channel
// One read in flight, data two edges after sample
// Mismatched ID or offset outside 0x200-0x3FF is ignored
// ----------------------------------------
`timescale 1ns/1ps

module aib_avalon_bridge (
  input  logic                   cfg_avmm_clk,      // Access clock
  input  logic                   rst_n,             // Sync reset
  input  aib_cfg_pkg::chan_id_t   cfg_avmm_addr_id,  // This channel's ID
  input  logic                   cfg_avmm_write,
  input  logic                   cfg_avmm_read,
  input  aib_cfg_pkg::avmm_addr_t cfg_avmm_addr,
  input  aib_cfg_pkg::csr_data_t  cfg_avmm_wdata,
  input  aib_cfg_pkg::byte_en_t   cfg_avmm_byte_en,
  output aib_cfg_pkg::csr_data_t  cfg_avmm_rdata,
  output logic                   cfg_avmm_rdatavld,
  output logic                   cfg_avmm_waitreq,
  output logic                   adapt_write,       // Adapter block strobes
  output logic                   adapt_read,
  output logic                   io_write,          // IO block strobes
  output logic                   io_read,
  output aib_cfg_pkg::csr_addr_t  csr_addr,
  output aib_cfg_pkg::csr_data_t  csr_wdata,
  output aib_cfg_pkg::byte_en_t   csr_byteen,
  input  aib_cfg_pkg::csr_data_t  adapt_rdata,
  input  aib_cfg_pkg::csr_data_t  io_rdata
);

  import aib_cfg_pkg::*;

  bridge_state_t state;
  bridge_state_t next_state;
  avmm_offset_t  offset;
  logic          id_match;
  logic          adapt_hit;
  logic          io_hit;
  logic          rd_req;
  logic          wr_req;
  csr_addr_t     rd_addr_q;  // Latched read offset
  logic          rd_io_q;    // Latched read targets IO block
  csr_data_t     rdata_q;

  // ----------------------------------------
  // Channel and range decode
  // ----------------------------------------
  assign offset    = cfg_avmm_addr[10:0];
  assign id_match  = (cfg_avmm_addr[16:11] == cfg_avmm_addr_id);
  assign adapt_hit = id_match & (offset >= AIB_BASE_BOT) & (offset < AIB_BASE_MID);
  assign io_hit    = id_match & (offset >= AIB_BASE_MID) & (offset < AIB_BASE_TOP);

  // Accesses are only taken in idle
  assign rd_req = (state == BR_IDLE) & cfg_avmm_read & (adapt_hit | io_hit);
  assign wr_req = (state == BR_IDLE) & cfg_avmm_write & ~cfg_avmm_read &
                  (adapt_hit | io_hit);

  // ----------------------------------------
  // Read sequencing
  // ----------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      BR_IDLE:  if (rd_req) next_state = BR_READ;
      BR_READ:  next_state = BR_RDVLD;
      BR_RDVLD: next_state = BR_IDLE;
      default:  next_state = BR_IDLE;
    endcase
  end

  always_ff @(posedge cfg_avmm_clk) begin
    if (!rst_n) begin
      state <= BR_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Host may drop controls once waitreq falls
  always_ff @(posedge cfg_avmm_clk) begin
    if (rd_req) begin
      rd_addr_q <= cfg_avmm_addr[7:0];
      rd_io_q   <= io_hit;
    end
  end

  // Blocks drive zero when not read, so OR merges
  always_ff @(posedge cfg_avmm_clk) begin
    if (state == BR_READ) rdata_q <= adapt_rdata | io_rdata;
  end

  // ----------------------------------------
  // Block strobes and host handshake
  // ----------------------------------------
  assign adapt_write = wr_req & adapt_hit;
  assign io_write    = wr_req & io_hit;
  assign adapt_read  = (state == BR_READ) & ~rd_io_q;
  assign io_read     = (state == BR_READ) & rd_io_q;
  assign csr_addr    = (state == BR_READ) ? rd_addr_q : cfg_avmm_addr[7:0];
  assign csr_wdata   = cfg_avmm_wdata;
  assign csr_byteen  = cfg_avmm_byte_en;

  assign cfg_avmm_waitreq  = rd_req | (state == BR_RDVLD); // Stall new read, hold busy
  assign cfg_avmm_rdatavld = (state == BR_RDVLD);          // Single cycle pulse
  assign cfg_avmm_rdata    = rdata_q;

endmodule

//--- verilog/aib_cfg_pkg.sv
// ----------------------------------------
// AIB channel CSR widths, offsets and types
// Offsets are byte addresses and word aligned
// ----------------------------------------
package aib_cfg_pkg;

  typedef logic [31:0] csr_data_t;    // Register and bus data
  typedef logic [7:0]  csr_addr_t;    // Offset inside one block
  typedef logic [3:0]  byte_en_t;     // Byte enables
  typedef logic [5:0]  chan_id_t;     // Channel ID
  typedef logic [16:0] avmm_addr_t;   // Host address
  typedef logic [10:0] avmm_offset_t; // Offset inside the channel
  typedef logic [2:0]  clk_div_sel_t; // One-hot, bit n selects divide by 2**n

  typedef enum logic [1:0] {
    BR_IDLE,  // Waiting for an access
    BR_READ,  // Block read strobe active
    BR_RDVLD  // Read data valid to host
  } bridge_state_t;

  // Channel range bounds
  localparam avmm_offset_t AIB_BASE_BOT = 11'h200;
  localparam avmm_offset_t AIB_BASE_MID = 11'h300;
  localparam avmm_offset_t AIB_BASE_TOP = 11'h400;

  // Adapter block map
  localparam csr_addr_t ADAPT_RX0_OFS    = 8'h00;
  localparam csr_addr_t ADAPT_RX1_OFS    = 8'h04;
  localparam csr_addr_t ADAPT_TX0_OFS    = 8'h08;
  localparam csr_addr_t ADAPT_TX1_OFS    = 8'h0C;
  localparam csr_addr_t ADAPT_CLKDIV_OFS = 8'h10;

  // IO block map
  localparam csr_addr_t IO_REDUND_OFS = 8'h00; // Register n at +4*n
  localparam csr_addr_t IO_RCOMP_OFS  = 8'h10;

  localparam clk_div_sel_t CLKDIV_RESET = 3'b001; // Divide by 1

  // Byte lanes with enable set take the new data
  function automatic csr_data_t byte_mask_wr(csr_data_t cur, csr_data_t wdata,
                                             byte_en_t be);
    csr_data_t res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

endpackage
